/* dv/fabric_cases.txt */
# name op address data expected, all hex
# dma rows take address as source, data as destination, expected as word count
ram_wr0      write_b    10000010  a5a51234  00000000
ram_rd0_b    read_b     10000010  00000000  a5a51234
ram_rd0_a    read_a     10000010  00000000  a5a51234
ram_wr1      write_b    100007fc  0badcafe  00000000
ram_rd1_a    read_a     100007fc  00000000  0badcafe
led_wr       write_b    40000000  fffff2a5  00000000
led_chk      check_led  00000000  00000000  000002a5
led_rd       read_b     40000000  00000000  00000000
unmap_rd_b   read_b     70000010  00000000  00000000
unmap_rd_a   read_a     7000fffc  00000000  00000000
unmap_wr     write_b    70000010  12345678  00000000
unmap_led    check_led  00000000  00000000  000002a5
unmap_ram    read_b     10000010  00000000  a5a51234
src_wr0      write_b    10000100  11110000  00000000
src_wr1      write_b    10000104  22220001  00000000
src_wr2      write_b    10000108  33330002  00000000
src_wr3      write_b    1000010c  44440003  00000000
ab_same_cyc  contend    10000020  5a5a0f0f  5a5a0f0f
dma_go       dma        10000100  10000200  00000004
dma_poll     wait_dma   00000000  00000000  00000000
dma_src_reg  read_b     90000000  00000000  10000110
dma_dst_reg  read_b     90000004  00000000  10000210
dma_cnt_reg  read_b     90000008  00000000  00000000
dst_rd0      read_a     10000200  00000000  11110000
dst_rd3      read_b     1000020c  00000000  44440003
dma_go2      dma        10000104  10000300  00000002
ab_during    contend    10000024  77778888  77778888
dma_poll2    wait_dma   00000000  00000000  00000000
dst2_rd1     read_a     10000304  00000000  33330002

/* project.f */
source/soc_pkg.sv
source/bus_if.sv
source/bus_access.sv
source/bus_decoder.sv
source/block_ram.sv
source/led_port.sv
source/dma_engine.sv
source/soc_fabric.sv
dv/soc_fabric_tb.sv

/* dv/soc_fabric_tb.sv */
`default_nettype none

module soc_fabric_tb;
	import soc_pkg::*;

	localparam int MAX_CASES = 64;
	localparam int RANDOM_OPS = 40;
	localparam addr_t RAM_BASE = 32'h1000_0000;
	localparam addr_t DMA_BASE = 32'h9000_0000;

	logic clock;
	logic rst_n;
	logic pa_request;
	addr_t pa_address;
	word_t pa_rdata;
	logic pa_ready;
	logic pb_request;
	logic pb_rw;
	addr_t pb_address;
	word_t pb_wdata;
	word_t pb_rdata;
	logic pb_ready;
	led_t led;

	// One row of the cases file per entry
	logic [8*16-1:0] case_name [MAX_CASES];
	logic [8*12-1:0] case_op [MAX_CASES];
	word_t case_addr [MAX_CASES];
	word_t case_data [MAX_CASES];
	word_t case_exp [MAX_CASES];
	int num_cases;
	int case_idx;

	// RAM mirror with a flag for each word that holds a defined value
	word_t model [RAM_WORDS];
	bit known [RAM_WORDS];
	addr_t dma_src;
	addr_t dma_dst;
	int dma_count;

	integer seed;
	int cycles = 0;
	int cycle_limit = 0;

	soc_fabric soc_fabric_inst (
		.clock(clock),
		.i_rst_n(rst_n),
		.i_pa_request(pa_request),
		.i_pa_address(pa_address),
		.o_pa_rdata(pa_rdata),
		.o_pa_ready(pa_ready),
		.i_pb_request(pb_request),
		.i_pb_rw(pb_rw),
		.i_pb_address(pb_address),
		.i_pb_wdata(pb_wdata),
		.o_pb_rdata(pb_rdata),
		.o_pb_ready(pb_ready),
		.o_led(led)
	);

	always
	begin
		#4 clock = ~clock;
	end

	task automatic stop_on_error;
		$display("*** FAILED ***");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	// Cycle budget and stray ready pulses
	always @(posedge clock)
	begin
		cycles <= cycles + 1;
		if (cycle_limit != 0)
		begin
			assert (cycles < cycle_limit)
			else
			begin
				$display("ERROR timeout, the run did not finish in %0d cycles", cycle_limit);
				stop_on_error();
			end
		end
		if (rst_n === 1'b1)
		begin
			assert ((!pa_ready || pa_request) && (!pb_ready || pb_request))
			else
			begin
				$display("ERROR a port saw ready without a pending request");
				stop_on_error();
			end
		end
	end

	function automatic logic [8:0] ram_index(input addr_t addr);
		return addr[10:2];
	endfunction

	function automatic logic in_ram(input addr_t addr);
		return addr[31:28] == REGION_RAM;
	endfunction

	function automatic void note_write(input addr_t addr, input word_t data);
		if (in_ram(addr))
		begin
			model[ram_index(addr)] = data;
			known[ram_index(addr)] = 1'b1;
		end
	endfunction

	task automatic check_value(input logic [8*16-1:0] name, input word_t expected,
		input word_t actual);
		assert (actual === expected)
		else
		begin
			$display("FAILED %0s expected %08h actual %08h", name, expected, actual);
			stop_on_error();
		end
	endtask

	task automatic check_ram(input logic [8*16-1:0] name, input addr_t addr,
		input word_t actual);
		assert (known[ram_index(addr)])
		else
		begin
			$display("ERROR %0s read a RAM word that was never written", name);
			stop_on_error();
		end
		check_value(name, model[ram_index(addr)], actual);
	endtask

	// ==================================================================
	// Port accesses that hold the request until ready
	// ==================================================================

	task automatic access_b(input logic rw, input addr_t addr, input word_t wdata,
		output word_t rdata);
		@(posedge clock);
		pb_request <= 1'b1;
		pb_rw <= rw;
		pb_address <= addr;
		pb_wdata <= wdata;
		@(posedge clock);
		while (pb_ready !== 1'b1)
			@(posedge clock);
		rdata = pb_rdata;
		pb_request <= 1'b0;
	endtask

	task automatic read_a(input addr_t addr, output word_t rdata);
		@(posedge clock);
		pa_request <= 1'b1;
		pa_address <= addr;
		@(posedge clock);
		while (pa_ready !== 1'b1)
			@(posedge clock);
		rdata = pa_rdata;
		pa_request <= 1'b0;
	endtask

	task automatic wait_dma_done(output word_t status);
		int k;
		status = 32'd1;
		while (status !== '0)
			access_b(1'b0, DMA_BASE + 32'hc, '0, status);
		// Mirror the finished copy
		for (k = 0; k < dma_count; k++)
		begin
			known[ram_index(dma_dst) + k] = known[ram_index(dma_src) + k];
			model[ram_index(dma_dst) + k] = model[ram_index(dma_src) + k];
		end
	endtask

	// ==================================================================
	// Cases file and random traffic
	// ==================================================================

	task automatic load_cases;
		int fd;
		int n;
		int dma_words;
		logic [8*16-1:0] tok;
		logic [8*12-1:0] op;
		logic [8*128-1:0] rest;
		word_t a;
		word_t d;
		word_t e;
		fd = $fopen("dv/fabric_cases.txt", "r");
		assert (fd != 0)
		else
		begin
			$display("ERROR cannot open dv/fabric_cases.txt");
			stop_on_error();
		end
		num_cases = 0;
		dma_words = 0;
		while ($fscanf(fd, "%s", tok) == 1)
		begin
			// A lone # opens a column note
			if (tok == "#")
				n = $fgets(rest, fd);
			else
			begin
				n = $fscanf(fd, "%s %h %h %h", op, a, d, e);
				assert (n == 4 && num_cases < MAX_CASES)
				else
				begin
					$display("ERROR cases file row %0s is malformed or one too many", tok);
					stop_on_error();
				end
				case_name[num_cases] = tok;
				case_op[num_cases] = op;
				case_addr[num_cases] = a;
				case_data[num_cases] = d;
				case_exp[num_cases] = e;
				if (op == "dma")
					dma_words += e;
				num_cases++;
			end
		end
		$fclose(fd);
		cycle_limit = 16 + 64 * (num_cases + RANDOM_OPS + dma_words);
	endtask

	task automatic run_case(input int i);
		word_t rd;
		word_t rd_a;
		case (case_op[i])
			"write_b":
			begin
				access_b(1'b1, case_addr[i], case_data[i], rd);
				note_write(case_addr[i], case_data[i]);
			end
			"read_b", "read_a":
			begin
				if (case_op[i] == "read_a")
					read_a(case_addr[i], rd);
				else
					access_b(1'b0, case_addr[i], '0, rd);
				check_value(case_name[i], case_exp[i], rd);
				if (in_ram(case_addr[i]))
					check_ram(case_name[i], case_addr[i], rd);
			end
			"check_led":
			begin
				// LED register takes the write on the completing edge
				@(posedge clock);
				check_value(case_name[i], case_exp[i], word_t'(led));
			end
			"dma":
			begin
				dma_src = case_addr[i];
				dma_dst = case_data[i];
				dma_count = case_exp[i];
				access_b(1'b1, DMA_BASE, dma_src, rd);
				access_b(1'b1, DMA_BASE + 32'h4, dma_dst, rd);
				access_b(1'b1, DMA_BASE + 32'h8, case_exp[i], rd);
			end
			"wait_dma":
			begin
				wait_dma_done(rd);
			end
			"contend":
			begin
				// Same cycle requests where B wins and A reads the new word
				fork
					read_a(case_addr[i], rd_a);
					access_b(1'b1, case_addr[i], case_data[i], rd);
				join
				note_write(case_addr[i], case_data[i]);
				check_value(case_name[i], case_exp[i], rd_a);
				check_ram(case_name[i], case_addr[i], rd_a);
			end
			default:
			begin
				$display("ERROR unknown operation on row %0d of the cases file", i);
				stop_on_error();
			end
		endcase
	endtask

	task automatic random_traffic;
		int k;
		word_t rnd;
		word_t data;
		word_t rd;
		logic [8:0] idx;
		addr_t addr;
		for (k = 0; k < RANDOM_OPS; k++)
		begin
			rnd = $random(seed);
			// Small window so reads often hit written words
			idx = 9'h180 + rnd[3:0];
			addr = RAM_BASE + {idx, 2'b00};
			if (rnd[5] || !known[idx])
			begin
				data = $random(seed);
				access_b(1'b1, addr, data, rd);
				note_write(addr, data);
			end
			else
			begin
				if (rnd[4])
					access_b(1'b0, addr, '0, rd);
				else
					read_a(addr, rd);
				check_ram("random", addr, rd);
			end
		end
	endtask

	initial
	begin
		clock = 1'b0;
		rst_n = 1'b0;
		pa_request = 1'b0;
		pa_address = '0;
		pb_request = 1'b0;
		pb_rw = 1'b0;
		pb_address = '0;
		pb_wdata = '0;
		seed = 32'h8ae4;
		load_cases();
		repeat (16)
			@(posedge clock);
		rst_n <= 1'b1;
		for (case_idx = 0; case_idx < num_cases; case_idx++)
			run_case(case_idx);
		random_traffic();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* source/soc_fabric.sv */
`default_nettype none

module soc_fabric (
	input wire clock,
	input wire i_rst_n,

	// Port A, read only
	input wire i_pa_request,
	input soc_pkg::addr_t i_pa_address,
	output soc_pkg::word_t o_pa_rdata,
	output logic o_pa_ready,

	// Port B, read and write
	input wire i_pb_request,
	input wire i_pb_rw,
	input soc_pkg::addr_t i_pb_address,
	input soc_pkg::word_t i_pb_wdata,
	output soc_pkg::word_t o_pb_rdata,
	output logic o_pb_ready,

	output soc_pkg::led_t o_led
);

	bus_if dma_bus();
	bus_if main_bus();
	bus_if ram_bus();
	bus_if led_bus();
	bus_if dma_regs();

	// ==================================================================
	// Arbiter and decoder
	// ==================================================================

	bus_access bus_access_inst (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_pa_request(i_pa_request),
		.i_pa_address(i_pa_address),
		.o_pa_ready(o_pa_ready),
		.o_pa_rdata(o_pa_rdata),
		.i_pb_request(i_pb_request),
		.i_pb_rw(i_pb_rw),
		.i_pb_address(i_pb_address),
		.i_pb_wdata(i_pb_wdata),
		.o_pb_ready(o_pb_ready),
		.o_pb_rdata(o_pb_rdata),
		.pc(dma_bus),
		.bus(main_bus)
	);

	bus_decoder bus_decoder_inst (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.cpu(main_bus),
		.ram(ram_bus),
		.led(led_bus),
		.dma(dma_regs)
	);

	// ==================================================================
	// Targets
	// ==================================================================

	block_ram block_ram_inst (
		.clock(clock),
		.bus(ram_bus)
	);

	led_port led_port_inst (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.bus(led_bus),
		.o_led(o_led)
	);

	// Slave on the decoder side, master toward arbiter port C
	dma_engine dma_engine_inst (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.regs(dma_regs),
		.bus(dma_bus)
	);

endmodule

`default_nettype wire

/* source/dma_engine.sv */
`default_nettype none

module dma_engine (
	input wire clock,
	input wire i_rst_n,
	bus_if.slave regs,
	bus_if.master bus
);
	import soc_pkg::*;

	dma_state_t state_q;
	addr_t src_q;
	addr_t dst_q;
	word_t count_q;
	word_t data_q;
	logic busy;
	logic [1:0] reg_idx;
	logic reg_write;

	assign busy = (state_q != dma_idle);
	assign reg_idx = regs.address[3:2];
	assign reg_write = regs.request && regs.rw;

	// ==================================================================
	// Copy machine and register writes
	// ==================================================================

	always_ff @(posedge clock)
	begin
		if (!i_rst_n)
		begin
			state_q <= dma_idle;
			src_q <= '0;
			dst_q <= '0;
			count_q <= '0;
		end
		else
		begin
			case (state_q)
				dma_idle:
				begin
					// Registers are locked while a transfer runs
					if (reg_write)
					begin
						case (reg_idx)
							DMA_REG_SRC: src_q <= regs.wdata;
							DMA_REG_DST: dst_q <= regs.wdata;
							DMA_REG_COUNT:
							begin
								count_q <= regs.wdata;
								if (regs.wdata != '0)
									state_q <= dma_read;
							end
							default: ;
						endcase
					end
				end
				dma_read:
				begin
					if (bus.ready)
						state_q <= dma_write;
				end
				dma_write:
				begin
					if (bus.ready)
					begin
						src_q <= src_q + addr_t'(4);
						dst_q <= dst_q + addr_t'(4);
						count_q <= count_q - word_t'(1);
						// Last word done
						if (count_q == word_t'(1))
							state_q <= dma_idle;
						else
							state_q <= dma_read;
					end
				end
				default: state_q <= dma_idle;
			endcase
		end
	end

	// Word in flight between the read and the write
	always_ff @(posedge clock)
	begin
		if (state_q == dma_read && bus.ready)
			data_q <= bus.rdata;
	end

	assign bus.request = busy;
	assign bus.rw = (state_q == dma_write);
	assign bus.address = (state_q == dma_write) ? dst_q : src_q;
	assign bus.wdata = data_q;

	// Register read-back
	always_comb
	begin
		case (reg_idx)
			DMA_REG_SRC: regs.rdata = src_q;
			DMA_REG_DST: regs.rdata = dst_q;
			DMA_REG_COUNT: regs.rdata = count_q;
			default: regs.rdata = word_t'(busy);
		endcase
	end

	assign regs.ready = regs.request;

	// Idle means the count ran out and the bus is released
	assert property (@(posedge clock) disable iff (!i_rst_n)
		(state_q == dma_idle) |-> (!bus.request && count_q == '0));

endmodule

`default_nettype wire

/* source/led_port.sv */
`default_nettype none

module led_port (
	input wire clock,
	input wire i_rst_n,
	bus_if.slave bus,
	output soc_pkg::led_t o_led
);
	import soc_pkg::*;

	led_t led_q;

	// Keep the low bits of the written word
	always_ff @(posedge clock)
	begin
		if (!i_rst_n)
			led_q <= '0;
		else if (bus.request && bus.rw)
			led_q <= bus.wdata[$bits(led_t)-1:0];
	end

	// Write-only register, reads come back as zero
	assign bus.rdata = '0;
	assign bus.ready = bus.request;

	assign o_led = led_q;

endmodule

`default_nettype wire

/* source/block_ram.sv */
`default_nettype none

module block_ram (
	input wire clock,
	bus_if.slave bus
);
	import soc_pkg::*;

	word_t mem [RAM_WORDS];
	logic [RAM_ADDR_W-1:0] word_idx;
	word_t rdata_q;
	logic ready_q;

	// Byte address to word index
	assign word_idx = bus.address[RAM_ADDR_W+1:2];

	always_ff @(posedge clock)
	begin
		if (bus.request && bus.rw)
			mem[word_idx] <= bus.wdata;
	end

	// Write returns the stored word, read returns the old contents
	always_ff @(posedge clock)
	begin
		if (bus.request)
		begin
			if (bus.rw)
				rdata_q <= bus.wdata;
			else
				rdata_q <= mem[word_idx];
		end
	end

	// One ready pulse per access, a held request starts the next one
	always_ff @(posedge clock)
	begin
		ready_q <= bus.request && !ready_q;
	end

	assign bus.rdata = rdata_q;
	assign bus.ready = ready_q;

	assert property (@(posedge clock)
		bus.ready |-> $past(bus.request));

endmodule

`default_nettype wire

/* source/bus_decoder.sv */
`default_nettype none

module bus_decoder (
	input wire clock,
	input wire i_rst_n,
	bus_if.slave cpu,
	bus_if.master ram,
	bus_if.master led,
	bus_if.master dma
);
	import soc_pkg::*;

	region_t region;
	logic sel_ram;
	logic sel_led;
	logic sel_dma;

	assign region = cpu.address[$bits(addr_t)-1 -: $bits(region_t)];

	assign sel_ram = (region == REGION_RAM);
	assign sel_led = (region == REGION_LED);
	assign sel_dma = (region == REGION_DMA);

	// Only the matching target sees a request
	assign ram.request = cpu.request && sel_ram;
	assign led.request = cpu.request && sel_led;
	assign dma.request = cpu.request && sel_dma;

	// Access fields fan out to every target
	assign ram.rw = cpu.rw;
	assign ram.address = cpu.address;
	assign ram.wdata = cpu.wdata;

	assign led.rw = cpu.rw;
	assign led.address = cpu.address;
	assign led.wdata = cpu.wdata;

	assign dma.rw = cpu.rw;
	assign dma.address = cpu.address;
	assign dma.wdata = cpu.wdata;

	// ==================================================================
	// Response multiplexer
	// ==================================================================

	assign cpu.rdata =
		sel_ram ? ram.rdata :
		sel_led ? led.rdata :
		sel_dma ? dma.rdata :
		'0;

	// Unmapped regions complete at once so a stray access cannot hang
	assign cpu.ready =
		sel_ram ? ram.ready :
		sel_led ? led.ready :
		sel_dma ? dma.ready :
		cpu.request;

	assert property (@(posedge clock) disable iff (!i_rst_n)
		$onehot0({ram.request, led.request, dma.request}));

endmodule

`default_nettype wire

/* source/bus_access.sv */
`default_nettype none

module bus_access (
	input wire clock,
	input wire i_rst_n,

	// Port A, instruction fetch
	input wire i_pa_request,
	input soc_pkg::addr_t i_pa_address,
	output logic o_pa_ready,
	output soc_pkg::word_t o_pa_rdata,

	// Port B, data
	input wire i_pb_request,
	input wire i_pb_rw,
	input soc_pkg::addr_t i_pb_address,
	input soc_pkg::word_t i_pb_wdata,
	output logic o_pb_ready,
	output soc_pkg::word_t o_pb_rdata,

	// Port C, DMA
	bus_if.slave pc,

	// Shared bus toward the decoder
	bus_if.master bus
);
	import soc_pkg::*;

	arb_state_t state_q;
	arb_state_t state_d;

	// Grant is chosen only from idle, so a running access is never cut
	always_comb
	begin
		state_d = state_q;
		case (state_q)
			arb_idle:
			begin
				if (i_pb_request)
					state_d = arb_grant_b;
				else if (pc.request)
					state_d = arb_grant_c;
				else if (i_pa_request)
					state_d = arb_grant_a;
			end
			default:
			begin
				if (bus.ready)
					state_d = arb_idle;
			end
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (!i_rst_n)
			state_q <= arb_idle;
		else
			state_q <= state_d;
	end

	// ==================================================================
	// Forward the granted master onto the bus
	// ==================================================================

	always_comb
	begin
		case (state_q)
			arb_grant_a:
			begin
				bus.request = i_pa_request;
				bus.rw = 1'b0;
				bus.address = i_pa_address;
				bus.wdata = '0;
			end
			arb_grant_b:
			begin
				bus.request = i_pb_request;
				bus.rw = i_pb_rw;
				bus.address = i_pb_address;
				bus.wdata = i_pb_wdata;
			end
			arb_grant_c:
			begin
				bus.request = pc.request;
				bus.rw = pc.rw;
				bus.address = pc.address;
				bus.wdata = pc.wdata;
			end
			default:
			begin
				bus.request = 1'b0;
				bus.rw = 1'b0;
				bus.address = '0;
				bus.wdata = '0;
			end
		endcase
	end

	// Response goes only to the owner of the grant
	assign o_pa_ready = (state_q == arb_grant_a) && bus.ready;
	assign o_pb_ready = (state_q == arb_grant_b) && bus.ready;
	assign pc.ready = (state_q == arb_grant_c) && bus.ready;

	assign o_pa_rdata = (state_q == arb_grant_a) ? bus.rdata : '0;
	assign o_pb_rdata = (state_q == arb_grant_b) ? bus.rdata : '0;
	assign pc.rdata = (state_q == arb_grant_c) ? bus.rdata : '0;

	// No bus traffic without a registered grant
	assert property (@(posedge clock) disable iff (!i_rst_n)
		(state_q == arb_idle) |-> !bus.request);

	// Granted master keeps its request up until the target answers
	assert property (@(posedge clock) disable iff (!i_rst_n)
		(bus.request && !bus.ready) |=> bus.request);

endmodule

`default_nettype wire

/* source/bus_if.sv */
`default_nettype none

interface bus_if;
	import soc_pkg::*;

	// Master side, held stable until ready
	logic request;
	logic rw;
	addr_t address;
	word_t wdata;

	// Slave side, rdata valid together with ready
	word_t rdata;
	logic ready;

	modport master (
		output request,
		output rw,
		output address,
		output wdata,
		input rdata,
		input ready
	);

	modport slave (
		input request,
		input rw,
		input address,
		input wdata,
		output rdata,
		output ready
	);

endinterface

`default_nettype wire

/* source/soc_pkg.sv */
`default_nettype none

package soc_pkg;

	// ==================================================================
	// Bus data types
	// ==================================================================

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [3:0] region_t;
	typedef logic [9:0] led_t;

	// Top address nibble of each target
	localparam region_t REGION_RAM = 4'h1;
	localparam region_t REGION_LED = 4'h4;
	localparam region_t REGION_DMA = 4'h9;

	// Block RAM geometry, word index from byte address bits 10:2
	localparam int RAM_WORDS = 512;
	localparam int RAM_ADDR_W = 9;

	// DMA register map, index from address bits 3:2
	localparam logic [1:0] DMA_REG_SRC = 2'd0;
	localparam logic [1:0] DMA_REG_DST = 2'd1;
	localparam logic [1:0] DMA_REG_COUNT = 2'd2;
	localparam logic [1:0] DMA_REG_STATUS = 2'd3;

	// ==================================================================
	// State machines
	// ==================================================================

	typedef enum logic [1:0] {
		arb_idle,
		arb_grant_a,
		arb_grant_b,
		arb_grant_c
	} arb_state_t;

	typedef enum logic [1:0] {
		dma_idle,
		dma_read,
		dma_write
	} dma_state_t;

endpackage

`default_nettype wire
